/* project.f */
+incdir+include
design/cache_pkg.sv
design/load_store_align.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
test/clock_gen.sv
test/cache_props.sv
test/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f project.f &&
	./obj_dir/Vcache_tb | tee sim.log &&
	grep -qx "Simulation passed" sim.log &&
	echo "run.sh: PASS" ||
	{ echo "run.sh: FAIL, see sim.log"; exit 1; }

/* test/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb;
	import cache_pkg::*;

	// operations per test in test order
	localparam int num_ops = 3 + 90 + 1 + 3 + 6 + 300;
	localparam int mem_words = 1024;

	logic clk;
	logic rst;
	logic ren;
	logic wen;
	addr_t addr;
	word_t din;
	load_kind_t load_kind;
	store_kind_t store_kind;
	logic cache_rdy;
	word_t dout;
	logic mem_ren;
	logic mem_wen;
	addr_t mem_addr;
	word_t mem_din;
	word_t mem_dout = '0;

	word_t mem [mem_words];
	logic [7:0] shadow [4*mem_words];
	addr_t rd_addrs [$];
	addr_t wr_addrs [$];
	// one entry per accepted request
	logic exp_read [$];
	word_t exp_val [$];
	logic rdy_d = 1'b0;
	string cur_test;
	int errors = 0;
	int errors_at_start;
	int tests_run = 0;
	int tests_failed = 0;
	int ops = 0;

	clock_gen clock_gen_inst (.clk(clk), .rst(rst));

	cache_top cache_top_inst (.*);

	// backing memory with read data one cycle after mem_ren
	always @(posedge clk) begin
		if (mem_ren)
			mem_dout <= mem[mem_addr[11:2]];
		if (mem_wen)
			mem[mem_addr[11:2]] <= mem_din;
	end

	always @(negedge clk) begin
		if (mem_ren)
			rd_addrs.push_back(mem_addr);
		if (mem_wen)
			wr_addrs.push_back(mem_addr);
	end

	function automatic word_t fill_word(int unsigned i);
		return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
	endfunction

	function automatic word_t ref_load(addr_t a, load_kind_t k);
		logic [7:0] b;
		logic [15:0] h;
		word_t w;
		b = shadow[a[11:0]];
		h = {shadow[a[11:0] + 1], shadow[a[11:0]]};
		w = {shadow[{a[11:2], 2'b11}], shadow[{a[11:2], 2'b10}],
			shadow[{a[11:2], 2'b01}], shadow[{a[11:2], 2'b00}]};
		case (k)
			LD_B:    return {{24{b[7]}}, b};
			LD_BU:   return {24'h0, b};
			LD_H:    return {{16{h[15]}}, h};
			LD_HU:   return {16'h0, h};
			default: return w;
		endcase
	endfunction

	task automatic shadow_store(addr_t a, store_kind_t k, word_t d);
		int n;
		n = (k == ST_B) ? 1 : (k == ST_H) ? 2 : 4;
		for (int i = 0; i < n; i++)
			shadow[a[11:0] + i] = d[8*i +: 8];
	endtask

	task automatic check(string what, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what,
				expected, actual);
			errors++;
		end
	endtask

	// dout is checked on every rising cache_rdy that ends a read
	always @(negedge clk) begin
		logic is_read;
		word_t expected;
		if (cache_rdy && !rdy_d && (exp_read.size() > 0)) begin
			is_read = exp_read.pop_front();
			expected = exp_val.pop_front();
			if (is_read)
				check("load result", expected, dout);
		end
		rdy_d = cache_rdy;
	end

	task automatic issue(logic write, addr_t a, word_t d, load_kind_t lk, store_kind_t sk);
		while (!cache_rdy)
			@(negedge clk);
		ren = !write;
		wen = write;
		addr = a;
		din = d;
		load_kind = lk;
		store_kind = sk;
		@(negedge clk);
		ren = 1'b0;
		wen = 1'b0;
		ops++;
		if (write)
			shadow_store(a, sk, d);
		exp_read.push_back(!write);
		exp_val.push_back(write ? '0 : ref_load(a, lk));
		while (!cache_rdy)
			@(negedge clk);
	endtask

	task automatic load(addr_t a, load_kind_t lk);
		issue(1'b0, a, '0, lk, ST_W);
	endtask

	task automatic store(addr_t a, store_kind_t sk, word_t d);
		issue(1'b1, a, d, LD_W, sk);
	endtask

	task automatic start_test(string name);
		cur_test = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		@(negedge clk);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - errors_at_start);
		end
	endtask

	initial begin
		addr_t a;
		int k;
		int off4;
		int off2;
		ren = 1'b0;
		wen = 1'b0;
		addr = '0;
		din = '0;
		load_kind = LD_W;
		store_kind = ST_W;
		void'($urandom(82261));
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = fill_word(i);
			for (int b = 0; b < 4; b++)
				shadow[4*i + b] = mem[i][8*b +: 8];
		end
		@(negedge clk);
		while (rst)
			@(negedge clk);

		start_test("word write and read");
		store(32'h040, ST_W, 32'hdead_beef);
		load(32'h040, LD_W);
		k = rd_addrs.size();
		load(32'h040, LD_W);
		check("mem_ren on repeat read", k, rd_addrs.size());
		finish_test();

		start_test("byte and halfword stores");
		for (int s = 0; s < 6; s++) begin
			store(32'h080, ST_W, $urandom);
			if (s < 4)
				store(32'h080 + s, ST_B, $urandom);
			else
				store(32'h080 + 2*(s - 4), ST_H, $urandom);
			for (int o = 0; o < 4; o++) begin
				load(32'h080 + o, LD_B);
				load(32'h080 + o, LD_BU);
			end
			for (int o = 0; o < 4; o += 2) begin
				load(32'h080 + o, LD_H);
				load(32'h080 + o, LD_HU);
			end
			load(32'h080, LD_W);
		end
		finish_test();

		start_test("read miss refill");
		rd_addrs.delete();
		load(32'h5a4, LD_W);
		check("memory value", mem[32'h5a4 >> 2], dout);
		check("mem_ren count", `CACHE_BLOCK_WORDS, rd_addrs.size());
		for (int i = 0; i < rd_addrs.size(); i++)
			check("mem_ren address", 32'h5a0 + 4*i, rd_addrs[i]);
		finish_test();

		// A, then two other tags of set 12
		start_test("dirty eviction");
		wr_addrs.delete();
		store(32'h0c8, ST_W, 32'h1234_5678);
		load(32'h1c0, LD_W);
		load(32'h2c0, LD_W);
		check("mem_wen count", `CACHE_BLOCK_WORDS, wr_addrs.size());
		for (int i = 0; i < wr_addrs.size(); i++)
			check("mem_wen address", 32'h0c0 + 4*i, wr_addrs[i]);
		for (int i = 0; i < `CACHE_BLOCK_WORDS; i++)
			check("written back word", ref_load(32'h0c0 + 4*i, LD_W),
				mem[(32'h0c0 >> 2) + i]);
		finish_test();

		// A, B, A again, then C evicts B
		start_test("lru replacement");
		load(32'h0e0, LD_W);
		load(32'h1e0, LD_W);
		load(32'h0e0, LD_W);
		load(32'h2e0, LD_W);
		rd_addrs.delete();
		load(32'h0e0, LD_W);
		check("mem_ren on re-read of A", 0, rd_addrs.size());
		load(32'h1e0, LD_W);
		check("mem_ren on re-read of B", `CACHE_BLOCK_WORDS, rd_addrs.size());
		finish_test();

		// 4 tags over 4 sets keeps evictions frequent
		start_test("random mix");
		for (int i = 0; i < 300; i++) begin
			a = (($urandom % 4) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
			k = $urandom % 8;
			off4 = $urandom % 4;
			off2 = 2 * ($urandom % 2);
			case (k)
				0: load(a + off4, LD_B);
				1: load(a + off4, LD_BU);
				2: load(a + off2, LD_H);
				3: load(a + off2, LD_HU);
				4: load(a, LD_W);
				5: store(a + off4, ST_B, $urandom);
				6: store(a + off2, ST_H, $urandom);
				default: store(a, ST_W, $urandom);
			endcase
		end
		finish_test();

		$display("%0d tests, %0d failed, %0d mismatches, %0d operations",
			tests_run, tests_failed, errors, ops);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// 40 cycles of 10 ns per operation plus a margin
	initial begin
		#(num_ops * 40 * 10 + 2000);
		$display("timeout: tests did not finish in %0d operations worth of cycles",
			num_ops);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* test/cache_props.sv */
`timescale 1ns/1ps

module cache_props (
	input logic clk,
	input logic rst,
	input logic accept,
	input logic hit,
	input logic cache_rdy,
	input logic mem_ren,
	input logic mem_wen
);

	// one memory direction per cycle
	assert property (@(posedge clk) disable iff (rst) !(mem_ren && mem_wen))
		else $error("mem_ren and mem_wen are high together");

	assert property (@(posedge clk) disable iff (rst) (mem_ren || mem_wen) |-> !cache_rdy)
		else $error("cache_rdy is high during a memory access");

	// lookup, access issue, access result
	assert property (@(posedge clk) disable iff (rst)
		accept ##1 hit |-> !cache_rdy ##1 !cache_rdy ##1 !cache_rdy ##1 cache_rdy)
		else $error("a hit did not complete 3 cycles after acceptance");

endmodule

bind cache_ctrl cache_props cache_props_inst (
	.clk       (clk),
	.rst       (rst),
	.accept    (accept),
	.hit       (hit),
	.cache_rdy (cache_rdy),
	.mem_ren   (mem_ren),
	.mem_wen   (mem_wen)
);

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic rst
);
	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over the first 3 rising edges
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

/* design/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ren,
	input  logic                   wen,
	input  cache_pkg::addr_t       addr,
	input  cache_pkg::word_t       din,
	input  cache_pkg::load_kind_t  load_kind,
	input  cache_pkg::store_kind_t store_kind,
	output logic                   cache_rdy,
	output cache_pkg::word_t       dout,
	output logic                   mem_ren,
	output logic                   mem_wen,
	output cache_pkg::addr_t       mem_addr,
	output cache_pkg::word_t       mem_din,
	input  cache_pkg::word_t       mem_dout
);

	// tag store
	cache_pkg::index_t index;
	cache_pkg::tag_t tag;
	logic touch_en;
	cache_pkg::way_t touch_way;
	logic fill_en;
	logic fill_dirty;
	logic dirty_set;
	logic hit;
	cache_pkg::way_t hit_way;
	cache_pkg::way_t victim_way;
	logic victim_dirty;
	cache_pkg::tag_t victim_tag;

	// data store
	cache_pkg::way_t way;
	cache_pkg::word_sel_t word_sel;
	cache_pkg::byte_en_t byte_en;
	cache_pkg::word_t wdata;
	cache_pkg::word_t rdata;

	// aligner
	logic [1:0] byte_off;
	cache_pkg::load_kind_t req_load_kind;
	cache_pkg::store_kind_t req_store_kind;
	cache_pkg::word_t req_data;
	cache_pkg::word_t store_lanes;
	cache_pkg::byte_en_t store_en;
	cache_pkg::word_t load_data;

	cache_ctrl cache_ctrl_inst (.*);

	tag_store tag_store_inst (.*);

	data_store data_store_inst (.*);

	load_store_align load_store_align_inst (
		.load_kind  (req_load_kind),
		.store_kind (req_store_kind),
		.store_data (req_data),
		.load_word  (rdata),
		.*
	);

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	// core port
	input  logic                   ren,
	input  logic                   wen,
	input  cache_pkg::addr_t       addr,
	input  cache_pkg::word_t       din,
	input  cache_pkg::load_kind_t  load_kind,
	input  cache_pkg::store_kind_t store_kind,
	output logic                   cache_rdy,
	output cache_pkg::word_t       dout,
	// memory port
	output logic                   mem_ren,
	output logic                   mem_wen,
	output cache_pkg::addr_t       mem_addr,
	output cache_pkg::word_t       mem_din,
	input  cache_pkg::word_t       mem_dout,
	// tag store
	output cache_pkg::index_t      index,
	output cache_pkg::tag_t        tag,
	output logic                   touch_en,
	output cache_pkg::way_t        touch_way,
	output logic                   fill_en,
	output logic                   fill_dirty,
	output logic                   dirty_set,
	input  logic                   hit,
	input  cache_pkg::way_t        hit_way,
	input  cache_pkg::way_t        victim_way,
	input  logic                   victim_dirty,
	input  cache_pkg::tag_t        victim_tag,
	// data store
	output cache_pkg::way_t        way,
	output cache_pkg::word_sel_t   word_sel,
	output cache_pkg::byte_en_t    byte_en,
	output cache_pkg::word_t       wdata,
	input  cache_pkg::word_t       rdata,
	// aligner
	output logic             [1:0] byte_off,
	output cache_pkg::load_kind_t  req_load_kind,
	output cache_pkg::store_kind_t req_store_kind,
	output cache_pkg::word_t       req_data,
	input  cache_pkg::word_t       store_lanes,
	input  cache_pkg::byte_en_t    store_en,
	input  cache_pkg::word_t       load_data
);
	import cache_pkg::*;

	localparam logic [`CACHE_WORD_SEL_W:0] last_step = `CACHE_BLOCK_WORDS;

	ctrl_state_t state;
	// block word counter, one extra step for the one-cycle lag
	logic [`CACHE_WORD_SEL_W:0] cnt;
	addr_t req_addr;
	logic req_wen;
	logic req_miss;
	word_sel_t req_word;
	word_sel_t cur_word;
	word_sel_t prev_word;
	word_t lane_mask;
	logic accept;
	logic acc_issue;
	logic acc_store;
	logic merge;

	assign {tag, index, req_word, byte_off} = req_addr;
	assign accept = (state == IDLE) && cache_rdy && (ren || wen);
	assign acc_issue = (state == ACCESS) && (cnt == '0);
	// store misses already merged their data during refill
	assign acc_store = acc_issue && req_wen && !req_miss;
	assign cur_word = cnt[`CACHE_WORD_SEL_W-1:0];
	assign prev_word = cur_word - 1'b1;
	assign merge = req_wen && (prev_word == req_word);

	always_comb begin
		for (int i = 0; i < `CACHE_DATA_W/8; i++) begin
			lane_mask[8*i +: 8] = {8{store_en[i]}};
		end
	end

	// memory port, write data is the array word read a cycle earlier
	assign mem_ren = (state == REFILL) && (cnt != last_step);
	assign mem_wen = (state == WRITEBACK) && (cnt != '0);
	assign mem_addr = (state == WRITEBACK) ? {victim_tag, index, prev_word, 2'b00}
		: {tag, index, cur_word, 2'b00};
	assign mem_din = rdata;

	assign touch_en = acc_issue;
	assign touch_way = hit_way;
	assign fill_en = (state == REFILL) && (cnt == last_step);
	assign fill_dirty = req_wen;
	assign dirty_set = acc_store;

	always_comb begin
		way = (state == ACCESS) ? hit_way : victim_way;
		word_sel = req_word;
		byte_en = '0;
		wdata = store_lanes;
		case (state)
			WRITEBACK: word_sel = cur_word;
			REFILL: begin
				// memory word lands one cycle after its read
				word_sel = prev_word;
				if (cnt != '0)
					byte_en = '1;
				if (merge)
					wdata = (mem_dout & ~lane_mask) | (store_lanes & lane_mask);
				else
					wdata = mem_dout;
			end
			ACCESS: begin
				if (acc_store)
					byte_en = store_en;
			end
			default: word_sel = req_word;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt <= '0;
			cache_rdy <= 1'b0;
			req_wen <= 1'b0;
			req_miss <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						state <= LOOKUP;
						cache_rdy <= 1'b0;
						req_wen <= wen;
					end else begin
						cache_rdy <= 1'b1;
					end
				end
				LOOKUP: begin
					cnt <= '0;
					req_miss <= !hit;
					if (hit)
						state <= ACCESS;
					else if (victim_dirty)
						state <= WRITEBACK;
					else
						state <= REFILL;
				end
				WRITEBACK: begin
					if (cnt == last_step) begin
						cnt <= '0;
						state <= REFILL;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				REFILL: begin
					if (cnt == last_step) begin
						cnt <= '0;
						state <= ACCESS;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ACCESS: begin
					// issue cycle then result cycle
					if (cnt == '0) begin
						cnt <= cnt + 1'b1;
					end else begin
						state <= IDLE;
						cache_rdy <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_data <= din;
			req_load_kind <= load_kind;
			req_store_kind <= store_kind;
		end
		if ((state == ACCESS) && (cnt != '0) && !req_wen)
			dout <= load_data;
	end

endmodule

/* design/data_store.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module data_store (
	input  logic                 clk,
	input  cache_pkg::way_t      way,
	input  cache_pkg::index_t    index,
	input  cache_pkg::word_sel_t word_sel,
	input  cache_pkg::byte_en_t  byte_en,
	input  cache_pkg::word_t     wdata,
	output cache_pkg::word_t     rdata
);
	import cache_pkg::*;

	word_t mem [`CACHE_WAYS][`CACHE_SETS][`CACHE_BLOCK_WORDS];

	// byte lane writes, read returns the old word on a collision
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CACHE_DATA_W/8; i++) begin
			if (byte_en[i])
				mem[way][index][word_sel][8*i +: 8] <= wdata[8*i +: 8];
		end
		rdata <= mem[way][index][word_sel];
	end

endmodule

/* design/tag_store.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module tag_store (
	input  logic              clk,
	input  logic              rst,
	input  cache_pkg::index_t index,
	input  cache_pkg::tag_t   tag,
	input  logic              touch_en,
	input  cache_pkg::way_t   touch_way,
	input  logic              fill_en,
	input  logic              fill_dirty,
	input  logic              dirty_set,
	output logic              hit,
	output cache_pkg::way_t   hit_way,
	output cache_pkg::way_t   victim_way,
	output logic              victim_dirty,
	output cache_pkg::tag_t   victim_tag
);
	import cache_pkg::*;

	tag_t tags [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] valid [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0] dirty [`CACHE_SETS];
	// holds the least recently used way of each set
	logic lru [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0] match;

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = valid[index][w] && (tags[index][w] == tag);
		end
	end

	assign hit = |match;
	assign hit_way = match[1];

	// empty way first, LRU way otherwise
	always_comb begin
		if (!valid[index][0])
			victim_way = 1'b0;
		else if (!valid[index][1])
			victim_way = 1'b1;
		else
			victim_way = lru[index];
	end

	assign victim_dirty = dirty[index][victim_way];
	assign victim_tag = tags[index][victim_way];

	always_ff @(posedge clk) begin
		if (fill_en)
			tags[index][victim_way] <= tag;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				lru[s] <= 1'b0;
			end
		end else begin
			if (fill_en) begin
				valid[index][victim_way] <= 1'b1;
				dirty[index][victim_way] <= fill_dirty;
			end
			if (dirty_set)
				dirty[index][touch_way] <= 1'b1;
			// the other way becomes the eviction candidate
			if (touch_en)
				lru[index] <= ~touch_way;
		end
	end

endmodule

/* design/load_store_align.sv */
`timescale 1ns/1ps

module load_store_align (
	input  logic                   [1:0] byte_off,
	input  cache_pkg::load_kind_t  load_kind,
	input  cache_pkg::store_kind_t store_kind,
	input  cache_pkg::word_t       store_data,
	input  cache_pkg::word_t       load_word,
	output cache_pkg::word_t       store_lanes,
	output cache_pkg::byte_en_t    store_en,
	output cache_pkg::word_t       load_data
);
	import cache_pkg::*;

	word_t shifted;

	// replicate the value so every lane holds it, the mask picks one
	always_comb begin
		case (store_kind)
			ST_B: begin
				store_lanes = {4{store_data[7:0]}};
				store_en = 4'b0001 << byte_off;
			end
			ST_H: begin
				store_lanes = {2{store_data[15:0]}};
				store_en = 4'b0011 << byte_off;
			end
			ST_W: begin
				store_lanes = store_data;
				store_en = 4'b1111;
			end
			default: begin
				store_lanes = store_data;
				store_en = 4'b0000;
			end
		endcase
	end

	assign shifted = load_word >> {byte_off, 3'b000};

	always_comb begin
		case (load_kind)
			LD_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
			LD_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
			LD_W:    load_data = load_word;
			LD_BU:   load_data = {24'h0, shifted[7:0]};
			LD_HU:   load_data = {16'h0, shifted[15:0]};
			default: load_data = '0;
		endcase
	end

endmodule

/* design/cache_pkg.sv */
package cache_pkg;
	`include "cache_params.svh"

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_DATA_W-1:0] word_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_WORD_SEL_W-1:0] word_sel_t;
	typedef logic way_t;
	typedef logic [`CACHE_DATA_W/8-1:0] byte_en_t;

	// one-hot load size and sign
	typedef enum logic [4:0] {
		LD_B  = 5'b00001,
		LD_H  = 5'b00010,
		LD_W  = 5'b00100,
		LD_BU = 5'b01000,
		LD_HU = 5'b10000
	} load_kind_t;

	// one-hot store size
	typedef enum logic [2:0] {
		ST_B = 3'b001,
		ST_H = 3'b010,
		ST_W = 3'b100
	} store_kind_t;

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, ACCESS} ctrl_state_t;

endpackage

/* include/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// address and data widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// geometry
`define CACHE_WAYS 2
`define CACHE_SETS 16
`define CACHE_BLOCK_WORDS 4

// address field widths
`define CACHE_INDEX_W 4
`define CACHE_WORD_SEL_W 2
`define CACHE_BYTE_OFF_W 2
// everything above index, word select and byte offset
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WORD_SEL_W - `CACHE_BYTE_OFF_W)

`endif
